/* build.f */
src/fpu_format_pkg.sv
src/fpu_ctrl_pkg.sv
src/fpu_classify.sv
src/fpu_add_path.sv
src/fpu_mul_path.sv
src/fpu_round_norm.sv
src/fpu_top.sv
sim/fpu_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = fpu_tb
FILELIST  = build.f

SRCS      = $(wildcard src/*.sv) $(wildcard sim/*.sv)
BIN       = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the testbench prints the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

/* sim/fpu_tb.sv */
module fpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fpu_format_pkg::*;
    import fpu_ctrl_pkg::*;

    localparam int STREAM_LEN = 32;
    // Exact 12, rounding 4, specials 4, range 5, then the stream
    localparam int NUM_OPS    = 12 + 4 + 4 + 5 + STREAM_LEN;
    localparam int LIMIT      = 2 * NUM_OPS + 50;

    localparam fp_word_t ONE        = 32'h3F80_0000;
    localparam fp_word_t TWO        = 32'h4000_0000;
    localparam fp_word_t HALF       = 32'h3F00_0000;
    localparam fp_word_t POS_INF    = 32'h7F80_0000;
    localparam fp_word_t MAX_FINITE = 32'h7F7F_FFFF;
    localparam fp_word_t MIN_NORMAL = 32'h0080_0000;
    localparam fp_word_t SNAN       = 32'h7F80_0001;   // Quiet bit clear
    localparam fp_word_t CANON_QNAN = 32'h7FC0_0000;

    // Flag bits in struct order from inf down to zero
    localparam fpu_flags_t F_NONE = 7'b000_0000;
    localparam fpu_flags_t F_INF  = 7'b100_0000;
    localparam fpu_flags_t F_SNAN = 7'b010_0000;
    localparam fpu_flags_t F_QNAN = 7'b001_0000;
    localparam fpu_flags_t F_INE  = 7'b000_1000;
    localparam fpu_flags_t F_OVF  = 7'b000_0100;
    localparam fpu_flags_t F_UNF  = 7'b000_0010;
    localparam fpu_flags_t F_ZERO = 7'b000_0001;

    typedef struct {
        fp_word_t   result;
        fpu_flags_t flags;
        int         due;      // Cycle at which the output is checked
        int         id;
    } expect_t;

    logic        clk;
    logic        rst;
    fp_word_t    opa, opb;
    fpu_op_e     fpu_op;
    round_mode_e rmode;
    fp_word_t    result;
    fpu_flags_t  flags;

    expect_t     pending[$];
    int          cycle;
    int          issued;
    int          checks;
    int          errors;
    integer      seed;

    fpu_top fpu_top_i (
        .clk    (clk),
        .rst    (rst),
        .opa    (opa),
        .opb    (opb),
        .fpu_op (fpu_op),
        .rmode  (rmode),
        .result (result),
        .flags  (flags)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Cycle count, timeout and output checker

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= LIMIT) begin
            $display("Timeout after %0d cycles with %0d results outstanding",
                     cycle, pending.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin : check_outputs
        expect_t e;
        while (pending.size() > 0 && pending[0].due <= cycle) begin
            e = pending.pop_front();
            checks += 2;
            assert (result == e.result) else begin
                errors++;
                $display("[ERROR] %0t op %0d result %h expected %h",
                         $time, e.id, result, e.result);
            end
            assert (flags == e.flags) else begin
                errors++;
                $display("[ERROR] %0t op %0d flags %b expected %b",
                         $time, e.id, flags, e.flags);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    // Drive one operation and queue what should come out 4 edges later
    task automatic issue_op(input fp_word_t a, input fp_word_t b, input fpu_op_e op,
                            input round_mode_e rm, input fp_word_t want,
                            input fpu_flags_t want_flags);
        expect_t e;
        @(negedge clk);
        opa      = a;
        opb      = b;
        fpu_op   = op;
        rmode    = rm;
        e.result = want;
        e.flags  = want_flags;
        e.due    = cycle + 4;
        e.id     = issued;
        pending.push_back(e);
        issued++;
    endtask

    // Exact single precision word for an integer below 2^24 in magnitude
    function automatic fp_word_t int_to_word(int v);
        int          mag;
        int          p;
        logic [31:0] m;
        if (v == 0) begin
            return '0;
        end
        mag = (v < 0) ? -v : v;
        p   = 0;
        for (int i = 0; i < 31; i++) begin
            if (mag[i]) begin
                p = i;
            end
        end
        m = mag << (23 - p);   // Leading one lands on the hidden bit
        return {v < 0, 8'(127 + p), m[22:0]};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic exact_arithmetic;
        round_mode_e modes[4];
        fp_word_t    zero_word;
        modes = '{RM_NEAREST, RM_ZERO, RM_POS_INF, RM_NEG_INF};
        foreach (modes[i]) begin
            zero_word = (modes[i] == RM_NEG_INF) ? 32'h8000_0000 : 32'h0000_0000;
            issue_op(32'h3FC0_0000, 32'h4010_0000, OP_ADD, modes[i], 32'h4070_0000, F_NONE);
            issue_op(32'h40A0_0000, 32'h40A0_0000, OP_SUB, modes[i], zero_word, F_ZERO);
            issue_op(32'h4040_0000, 32'hC000_0000, OP_MUL, modes[i], 32'hC0C0_0000, F_NONE);
        end
    endtask

    task automatic rounding_modes;
        fp_word_t tiny;
        tiny = 32'h3380_0000;   // 2^-24 is exactly half an ulp of 1.0
        issue_op(ONE, tiny, OP_ADD, RM_NEAREST, ONE, F_INE);           // Tie goes to even
        issue_op(ONE, tiny, OP_ADD, RM_POS_INF, 32'h3F80_0001, F_INE);
        issue_op(ONE, tiny, OP_ADD, RM_ZERO, ONE, F_INE);
        issue_op(ONE, tiny, OP_ADD, RM_NEG_INF, ONE, F_INE);
    endtask

    task automatic special_operands;
        issue_op(SNAN, ONE, OP_ADD, RM_NEAREST, CANON_QNAN, F_SNAN | F_QNAN);
        issue_op(POS_INF, POS_INF, OP_SUB, RM_NEAREST, CANON_QNAN, F_QNAN);
        issue_op(32'h0000_0000, POS_INF, OP_MUL, RM_NEAREST, CANON_QNAN, F_QNAN);
        issue_op(POS_INF, ONE, OP_ADD, RM_NEAREST, POS_INF, F_INF);
    endtask

    task automatic range_limits;
        issue_op(MAX_FINITE, TWO, OP_MUL, RM_NEAREST, POS_INF, F_INF | F_OVF | F_INE);
        issue_op(MAX_FINITE, TWO, OP_MUL, RM_ZERO, MAX_FINITE, F_OVF | F_INE);
        issue_op(MIN_NORMAL, HALF, OP_MUL, RM_NEAREST, 32'h0000_0000,
                 F_UNF | F_INE | F_ZERO);
        // Denormals count as zero
        issue_op(32'h0000_0001, ONE, OP_ADD, RM_NEAREST, ONE, F_NONE);
        issue_op(32'h0040_0000, TWO, OP_MUL, RM_NEAREST, 32'h0000_0000, F_ZERO);
    endtask

    task automatic back_to_back_stream;
        int       a, b, r, op_idx;
        fpu_op_e  op;
        fp_word_t want;
        for (int k = 0; k < STREAM_LEN; k++) begin
            a      = 1 + int'($unsigned($random(seed)) % 64);
            b      = 1 + int'($unsigned($random(seed)) % 64);
            op_idx = int'($unsigned($random(seed)) % 3);
            if ($random(seed) & 1) begin
                a = -a;
            end
            if ($random(seed) & 1) begin
                b = -b;
            end
            case (op_idx)
                0: begin
                    op = OP_ADD;
                    r  = a + b;
                end
                1: begin
                    op = OP_SUB;
                    r  = a - b;
                end
                default: begin
                    op = OP_MUL;
                    r  = a * b;
                end
            endcase
            want = int_to_word(r);
            issue_op(int_to_word(a), int_to_word(b), op, RM_NEAREST, want,
                     (r == 0) ? F_ZERO : F_NONE);   // Cancellation gives +0
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        $timeformat(-9, 1, " ns", 0);
        seed   = 32'h5eb8_23d8;
        clk    = 1'b0;
        rst    = 1'b1;
        opa    = '0;
        opb    = '0;
        fpu_op = OP_ADD;
        rmode  = RM_NEAREST;
        cycle  = 0;
        issued = 0;
        checks = 0;
        errors = 0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checks++;
        assert (result == '0 && flags == '0) else begin
            errors++;
            $display("[ERROR] %0t outputs after reset %h %b", $time, result, flags);
        end

        exact_arithmetic();
        rounding_modes();
        special_operands();
        range_limits();
        back_to_back_stream();

        while (pending.size() != 0) begin
            @(negedge clk);
        end

        $display("Summary: %0d operations, %0d checks, %0d errors", issued, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src/fpu_top.sv */
module fpu_top (
    input  logic                      clk,
    input  logic                      rst,
    input  fpu_format_pkg::fp_word_t  opa,
    input  fpu_format_pkg::fp_word_t  opb,
    input  fpu_ctrl_pkg::fpu_op_e     fpu_op,
    input  fpu_ctrl_pkg::round_mode_e rmode,
    output fpu_format_pkg::fp_word_t  result,
    output fpu_ctrl_pkg::fpu_flags_t  flags
);
    import fpu_format_pkg::*;
    import fpu_ctrl_pkg::*;

    fp_word_t    opa_s1, opb_s1;
    logic        sub_s1;          // Subtract request at stage 1
    fpu_op_e     op_s3;
    round_mode_e rmode_s3;
    special_t    special_s3;
    raw_result_t add_raw, mul_raw;

    fpu_classify u_classify (
        .clk        (clk),
        .rst        (rst),
        .opa        (opa),
        .opb        (opb),
        .fpu_op     (fpu_op),
        .rmode      (rmode),
        .opa_q      (opa_s1),
        .opb_q      (opb_s1),
        .sub_q      (sub_s1),
        .op_s3      (op_s3),
        .rmode_s3   (rmode_s3),
        .special_s3 (special_s3)
    );

    fpu_add_path u_add_path (
        .clk (clk),
        .rst (rst),
        .opa (opa_s1),
        .opb (opb_s1),
        .sub (sub_s1),
        .raw (add_raw)
    );

    fpu_mul_path u_mul_path (
        .clk (clk),
        .rst (rst),
        .opa (opa_s1),
        .opb (opb_s1),
        .raw (mul_raw)
    );

    fpu_round_norm u_round_norm (
        .clk     (clk),
        .rst     (rst),
        .add_raw (add_raw),
        .mul_raw (mul_raw),
        .op      (op_s3),
        .rmode   (rmode_s3),
        .special (special_s3),
        .result  (result),
        .flags   (flags)
    );

endmodule

/* src/fpu_round_norm.sv */
module fpu_round_norm (
    input  logic                        clk,
    input  logic                        rst,
    input  fpu_format_pkg::raw_result_t add_raw,
    input  fpu_format_pkg::raw_result_t mul_raw,
    input  fpu_ctrl_pkg::fpu_op_e       op,
    input  fpu_ctrl_pkg::round_mode_e   rmode,
    input  fpu_ctrl_pkg::special_t      special,
    output fpu_format_pkg::fp_word_t    result,
    output fpu_ctrl_pkg::fpu_flags_t    flags
);
    import fpu_format_pkg::*;
    import fpu_ctrl_pkg::*;

    localparam int MANT_W = $bits(raw_result_t) - $bits(wide_exp_t) - 1;
    localparam int HID    = FRAC_W + 3;   // Hidden bit position in the raw mantissa

    raw_result_t       sel;
    logic [4:0]        lead, lshift;
    logic [MANT_W-1:0] shifted;
    ext_mant_t         norm;
    wide_exp_t         exp_n, exp_r;
    logic              inexact, rnd_inc;
    logic [FRAC_W+1:0] rounded;           // Rounding carry on top
    frac_t             frac_r;
    logic              is_zero, ovf, unf, zero_sign;
    fp_word_t          result_d;
    fpu_flags_t        flags_d;

    //////////////////////////////////////////////////////////////////////
    // Select and normalize

    always_comb begin
        sel  = (op == OP_MUL) ? mul_raw : add_raw;
        lead = '0;
        for (int i = 0; i < MANT_W; i++) begin
            if (sel.mant[i]) lead = i[4:0];
        end
        is_zero = (sel.mant == '0);
        lshift  = 5'(HID) - lead;
        shifted = sel.mant << lshift;
        if (lead == 5'(HID + 1)) begin   // Carry out needs a right shift by one
            norm  = {sel.mant[MANT_W-1:2], |sel.mant[1:0]};
            exp_n = sel.exp + 10'sd1;
        end else begin
            norm  = shifted[HID:0];
            exp_n = sel.exp - wide_exp_t'({5'b0, lshift});
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Round and range check

    always_comb begin
        inexact = |norm[2:0];
        case (rmode)
            RM_NEAREST: rnd_inc = norm[2] && (norm[1] || norm[0] || norm[3]);
            RM_ZERO:    rnd_inc = 1'b0;
            RM_POS_INF: rnd_inc = inexact && !sel.sign;
            default:    rnd_inc = inexact && sel.sign;
        endcase
        rounded = {1'b0, norm[HID:3]} + {{(FRAC_W+1){1'b0}}, rnd_inc};
        if (rounded[FRAC_W+1]) begin   // Mantissa wrapped to 2.0
            frac_r = rounded[FRAC_W:1];
            exp_r  = exp_n + 10'sd1;
        end else begin
            frac_r = rounded[FRAC_W-1:0];
            exp_r  = exp_n;
        end
        ovf = !is_zero && (exp_r > wide_exp_t'((1 << EXP_W) - 2));
        unf = !is_zero && !ovf && (exp_r < wide_exp_t'(1));
        // Exact cancellation is +0 except when rounding down
        zero_sign = (op == OP_MUL) ? sel.sign : (rmode == RM_NEG_INF);
    end

    always_comb begin
        flags_d = '0;
        if (special.forced) begin
            if (special.is_nan) begin
                result_d     = QNAN_WORD;
                flags_d.qnan = 1'b1;
            end else begin
                result_d    = {special.inf_sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
                flags_d.inf = 1'b1;
            end
            flags_d.snan = special.snan_seen;
        end else if (is_zero) begin
            result_d     = {zero_sign, {(EXP_W+FRAC_W){1'b0}}};
            flags_d.zero = 1'b1;
        end else if (ovf) begin
            result_d         = overflow_word(rmode, sel.sign);
            flags_d.inf      = &result_d[FRAC_W +: EXP_W];
            flags_d.overflow = 1'b1;
            flags_d.ine      = 1'b1;
        end else if (unf) begin   // Flush to signed zero
            result_d          = {sel.sign, {(EXP_W+FRAC_W){1'b0}}};
            flags_d.underflow = 1'b1;
            flags_d.ine       = 1'b1;
            flags_d.zero      = 1'b1;
        end else begin
            result_d    = {sel.sign, exp_r[EXP_W-1:0], frac_r};
            flags_d.ine = inexact;
        end
    end

    // Stage 4 output registers
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
            flags  <= '0;
        end else begin
            result <= result_d;
            flags  <= flags_d;
        end
    end

    a_ovf_inexact: assert property (@(posedge clk) disable iff (rst)
        flags.overflow |-> flags.ine)
        else $error("overflow reported without ine");

    a_nan_not_inf: assert property (@(posedge clk) disable iff (rst)
        !(flags.qnan && flags.inf))
        else $error("qnan and inf reported together");

endmodule

/* src/fpu_mul_path.sv */
module fpu_mul_path (
    input  logic                        clk,
    input  logic                        rst,
    input  fpu_format_pkg::fp_word_t    opa,
    input  fpu_format_pkg::fp_word_t    opb,
    output fpu_format_pkg::raw_result_t raw
);
    import fpu_format_pkg::*;

    localparam int PROD_W = 2 * $bits(mant_t);
    localparam int EXT_W  = $bits(ext_mant_t);

    exp_t              exp_a, exp_b;
    mant_t             mant_a, mant_b;

    // Stage 2 registers
    logic              sign_s2;
    wide_exp_t         exp_s2;
    logic [PROD_W-1:0] prod_s2;

    always_comb begin
        exp_a  = opa[FRAC_W +: EXP_W];
        exp_b  = opb[FRAC_W +: EXP_W];
        mant_a = (exp_a == '0) ? '0 : {1'b1, opa[FRAC_W-1:0]};   // Denormal as zero
        mant_b = (exp_b == '0) ? '0 : {1'b1, opb[FRAC_W-1:0]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sign_s2 <= 1'b0;
        end else begin
            sign_s2 <= opa[EXP_W+FRAC_W] ^ opb[EXP_W+FRAC_W];
        end
    end

    always_ff @(posedge clk) begin
        exp_s2  <= wide_exp_t'({2'b00, exp_a}) + wide_exp_t'({2'b00, exp_b})
                 - wide_exp_t'(BIAS);
        prod_s2 <= mant_a * mant_b;
    end

    // Product top bit is the carry and the low bits fold into sticky
    always_ff @(posedge clk) begin
        if (rst) begin
            raw <= '0;
        end else begin
            raw.sign <= sign_s2;
            raw.exp  <= exp_s2;
            raw.mant <= {prod_s2[PROD_W-1 -: EXT_W], |prod_s2[PROD_W-EXT_W-1:0]};
        end
    end

endmodule

/* src/fpu_add_path.sv */
module fpu_add_path (
    input  logic                        clk,
    input  logic                        rst,
    input  fpu_format_pkg::fp_word_t    opa,
    input  fpu_format_pkg::fp_word_t    opb,
    input  logic                        sub,
    output fpu_format_pkg::raw_result_t raw
);
    import fpu_format_pkg::*;

    localparam int EXT_W = $bits(ext_mant_t);

    logic [EXP_W+FRAC_W-1:0] mag_a, mag_b, mag_big, mag_small;
    logic                    sign_a, sign_b, swap;
    logic                    sign_big, sign_small;
    exp_t                    exp_big, exp_small, exp_diff;
    mant_t                   mant_big, mant_small;
    logic [4:0]              shamt;
    logic [2*EXT_W-1:0]      shift_win;
    ext_mant_t               ext_big, ext_small;

    // Stage 2 registers
    ext_mant_t               big_s2, small_s2;
    exp_t                    exp_s2;
    logic                    sign_s2, eff_sub_s2;
    logic [EXT_W:0]          sum;

    //////////////////////////////////////////////////////////////////////
    // Swap and align

    always_comb begin
        // Magnitudes with denormals forced to zero
        mag_a  = (opa[FRAC_W +: EXP_W] == '0) ? '0 : opa[EXP_W+FRAC_W-1:0];
        mag_b  = (opb[FRAC_W +: EXP_W] == '0) ? '0 : opb[EXP_W+FRAC_W-1:0];
        sign_a = opa[EXP_W+FRAC_W];
        sign_b = opb[EXP_W+FRAC_W] ^ sub;   // Subtraction flips b
        swap   = (mag_b > mag_a);

        mag_big    = swap ? mag_b : mag_a;
        mag_small  = swap ? mag_a : mag_b;
        sign_big   = swap ? sign_b : sign_a;
        sign_small = swap ? sign_a : sign_b;

        exp_big    = mag_big[FRAC_W +: EXP_W];
        exp_small  = mag_small[FRAC_W +: EXP_W];
        mant_big   = {|exp_big, mag_big[FRAC_W-1:0]};
        mant_small = {|exp_small, mag_small[FRAC_W-1:0]};

        exp_diff  = exp_big - exp_small;
        shamt     = (exp_diff > exp_t'(EXT_W)) ? 5'(EXT_W) : exp_diff[4:0];
        ext_big   = {mant_big, 3'b000};
        shift_win = {mant_small, 3'b000, {EXT_W{1'b0}}} >> shamt;
        // Everything shifted out lands in sticky
        ext_small = {shift_win[2*EXT_W-1:EXT_W+1], shift_win[EXT_W] | (|shift_win[EXT_W-1:0])};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sign_s2    <= 1'b0;
            eff_sub_s2 <= 1'b0;
        end else begin
            sign_s2    <= sign_big;
            eff_sub_s2 <= sign_big ^ sign_small;
        end
    end

    always_ff @(posedge clk) begin
        big_s2   <= ext_big;
        small_s2 <= ext_small;
        exp_s2   <= exp_big;
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 3 add or subtract

    // Never negative since the larger magnitude comes first
    assign sum = eff_sub_s2 ? ({1'b0, big_s2} - {1'b0, small_s2})
                            : ({1'b0, big_s2} + {1'b0, small_s2});

    always_ff @(posedge clk) begin
        if (rst) begin
            raw <= '0;
        end else begin
            raw.sign <= sign_s2;
            raw.exp  <= wide_exp_t'({2'b00, exp_s2});
            raw.mant <= sum;
        end
    end

    a_big_first: assert property (@(posedge clk) disable iff (rst) big_s2 >= small_s2)
        else $error("aligned operands out of order");

endmodule

/* src/fpu_classify.sv */
module fpu_classify (
    input  logic                      clk,
    input  logic                      rst,
    input  fpu_format_pkg::fp_word_t  opa,
    input  fpu_format_pkg::fp_word_t  opb,
    input  fpu_ctrl_pkg::fpu_op_e     fpu_op,
    input  fpu_ctrl_pkg::round_mode_e rmode,
    output fpu_format_pkg::fp_word_t  opa_q,
    output fpu_format_pkg::fp_word_t  opb_q,
    output logic                      sub_q,
    output fpu_ctrl_pkg::fpu_op_e     op_s3,
    output fpu_ctrl_pkg::round_mode_e rmode_s3,
    output fpu_ctrl_pkg::special_t    special_s3
);
    import fpu_format_pkg::*;
    import fpu_ctrl_pkg::*;

    fpu_op_e     op_s1, op_s2;
    round_mode_e rmode_s1, rmode_s2;
    fp_class_t   cls_a, cls_b;
    special_t    special_d, special_s2;
    logic        is_mul, eff_sub, nan_res, inf_res;

    function automatic fp_class_t classify(fp_word_t w);
        exp_t      e;
        frac_t     f;
        fp_class_t c;
        e = w[FRAC_W +: EXP_W];
        f = w[FRAC_W-1:0];
        c.sign    = w[EXP_W+FRAC_W];
        c.is_zero = (e == '0);            // Denormal flushed
        c.is_inf  = (&e) && (f == '0);
        c.is_nan  = (&e) && (f != '0);
        c.is_snan = c.is_nan && !f[FRAC_W-1];
        return c;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stage 1 input registers

    always_ff @(posedge clk) begin
        opa_q <= opa;
        opb_q <= opb;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sub_q    <= 1'b0;
            op_s1    <= OP_ADD;
            rmode_s1 <= RM_NEAREST;
        end else begin
            sub_q    <= (fpu_op == OP_SUB);
            op_s1    <= fpu_op;
            rmode_s1 <= rmode;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Special result decision

    always_comb begin
        cls_a   = classify(opa_q);
        cls_b   = classify(opb_q);
        is_mul  = (op_s1 == OP_MUL);
        eff_sub = sub_q ^ cls_a.sign ^ cls_b.sign;
        nan_res = cls_a.is_nan || cls_b.is_nan
               || (!is_mul && cls_a.is_inf && cls_b.is_inf && eff_sub)   // inf - inf
               || (is_mul && ((cls_a.is_zero && cls_b.is_inf) || (cls_a.is_inf && cls_b.is_zero)));
        inf_res = cls_a.is_inf || cls_b.is_inf;
        special_d.forced    = nan_res || inf_res;
        special_d.is_nan    = nan_res;
        special_d.inf_sign  = is_mul ? (cls_a.sign ^ cls_b.sign)
                            : cls_a.is_inf ? cls_a.sign : (cls_b.sign ^ sub_q);
        special_d.snan_seen = cls_a.is_snan || cls_b.is_snan;
    end

    // Delay to meet the datapaths at stage 3
    always_ff @(posedge clk) begin
        if (rst) begin
            special_s2 <= '0;
            special_s3 <= '0;
            op_s2      <= OP_ADD;
            op_s3      <= OP_ADD;
            rmode_s2   <= RM_NEAREST;
            rmode_s3   <= RM_NEAREST;
        end else begin
            special_s2 <= special_d;
            special_s3 <= special_s2;
            op_s2      <= op_s1;
            op_s3      <= op_s2;
            rmode_s2   <= rmode_s1;
            rmode_s3   <= rmode_s2;
        end
    end

    a_snan_forces_nan: assert property (@(posedge clk) disable iff (rst)
        special_s3.snan_seen |-> (special_s3.forced && special_s3.is_nan))
        else $error("signalling NaN did not force a NaN result");

endmodule

/* src/fpu_ctrl_pkg.sv */
package fpu_ctrl_pkg;

    import fpu_format_pkg::*;

    typedef enum logic [1:0] {
        OP_ADD = 2'b00,
        OP_SUB = 2'b01,
        OP_MUL = 2'b10
    } fpu_op_e;

    typedef enum logic [1:0] {
        RM_NEAREST = 2'b00,   // Ties to even
        RM_ZERO    = 2'b01,
        RM_POS_INF = 2'b10,
        RM_NEG_INF = 2'b11
    } round_mode_e;

    typedef struct packed {
        logic forced;      // Result comes from the special rules
        logic is_nan;      // Forced result is a NaN, otherwise infinity
        logic inf_sign;
        logic snan_seen;
    } special_t;

    typedef struct packed {
        logic inf;
        logic snan;
        logic qnan;
        logic ine;
        logic overflow;
        logic underflow;
        logic zero;
    } fpu_flags_t;

    // Overflowed value for a rounding mode
    // Largest finite when rounding heads toward zero, infinity otherwise
    function automatic fp_word_t overflow_word(round_mode_e rm, logic sign);
        logic to_max;
        to_max = (rm == RM_ZERO) || (rm == RM_POS_INF && sign) || (rm == RM_NEG_INF && !sign);
        if (to_max) begin
            return {sign, {(EXP_W-1){1'b1}}, 1'b0, {FRAC_W{1'b1}}};
        end
        return {sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
    endfunction

endpackage

/* src/fpu_format_pkg.sv */
package fpu_format_pkg;

    localparam int EXP_W  = 8;    // Biased exponent field
    localparam int FRAC_W = 23;   // Stored fraction field
    localparam int BIAS   = 127;

    typedef logic [EXP_W+FRAC_W:0]   fp_word_t;
    typedef logic [EXP_W-1:0]        exp_t;
    typedef logic signed [EXP_W+1:0] wide_exp_t;  // Headroom for overflow and underflow
    typedef logic [FRAC_W-1:0]       frac_t;
    typedef logic [FRAC_W:0]         mant_t;      // Hidden bit on top
    typedef logic [FRAC_W+3:0]       ext_mant_t;  // Mantissa plus guard, round, sticky

    // Canonical quiet NaN with positive sign
    localparam fp_word_t QNAN_WORD = {1'b0, {EXP_W{1'b1}}, 1'b1, {(FRAC_W-1){1'b0}}};

    // Operand class
    typedef struct packed {
        logic sign;
        logic is_zero;   // Denormals count here too
        logic is_inf;
        logic is_nan;
        logic is_snan;
    } fp_class_t;

    // Datapath result ahead of normalization
    // Value is mant * 2^(exp - BIAS - FRAC_W - 3), hidden bit at mant[FRAC_W+3]
    typedef struct packed {
        logic              sign;
        wide_exp_t         exp;
        logic [FRAC_W+4:0] mant;   // Carry bit over an ext_mant_t
    } raw_result_t;

endpackage
